/* csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // machine data width.
    localparam int xlen = 32;

    typedef logic [11:0] csr_addr_t;

    // machine trap setup.
    localparam csr_addr_t addr_mstatus  = 12'h300;
    localparam csr_addr_t addr_mie      = 12'h304;
    localparam csr_addr_t addr_mtvec    = 12'h305;

    // machine trap handling.
    localparam csr_addr_t addr_mscratch = 12'h340;
    localparam csr_addr_t addr_mepc     = 12'h341;
    localparam csr_addr_t addr_mcause   = 12'h342;
    localparam csr_addr_t addr_mtval    = 12'h343;
    localparam csr_addr_t addr_mip      = 12'h344;

    // mstatus fields kept in this core, mpp is two bits wide.
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mstatus_mpp_lsb  = 11;

    // bit positions shared by mip and mie.
    localparam int irq_msip_bit = 3;
    localparam int irq_mtip_bit = 7;
    localparam int irq_meip_bit = 11;

    // one csr write from the pipeline, valid for a single cycle.
    typedef struct packed {
        logic                  wr;
        csr_addr_t             addr;
        logic [xlen-1:0]       data;
    } csr_wr_t;

endpackage

`default_nettype wire

/* csr_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_regs (
    input  logic                        clk,
    input  logic                        rstn,
    input  csr_pkg::csr_wr_t            csr_w,
    input  csr_pkg::csr_addr_t          csr_raddr,
    input  logic                        trap_en,
    input  logic                        take_irq,
    input  trap_pkg::irq_bits_t         pending,
    input  trap_pkg::cause_word_t       mcause,
    input  logic [csr_pkg::xlen-1:0]    mstatus_word,
    input  logic [csr_pkg::xlen-1:0]    mepc,
    input  logic [csr_pkg::xlen-1:0]    mtval,
    output trap_pkg::irq_bits_t         enables,
    output logic [csr_pkg::xlen-1:0]    trap_vec,
    output logic [csr_pkg::xlen-1:0]    csr_rdata
);

    logic [csr_pkg::xlen-1:0] mtvec;
    logic [csr_pkg::xlen-1:0] mscratch;
    logic [csr_pkg::xlen-1:0] mtvec_base;
    logic [csr_pkg::xlen-1:0] vec_off;
    logic [csr_pkg::xlen-2:0] vec_code;
    logic [csr_pkg::xlen-1:0] mie_word;
    logic [csr_pkg::xlen-1:0] mip_word;
    logic                     wr_ok;

    // writes are dropped while a trap or interrupt is being taken.
    assign wr_ok = csr_w.wr && !trap_en && !take_irq;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            enables  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
        end else if (wr_ok) begin
            case (csr_w.addr)
                csr_pkg::addr_mie: begin
                    enables.meip <= csr_w.data[csr_pkg::irq_meip_bit];
                    enables.mtip <= csr_w.data[csr_pkg::irq_mtip_bit];
                    enables.msip <= csr_w.data[csr_pkg::irq_msip_bit];
                end
                // bit 1 of mtvec is reserved and reads zero.
                csr_pkg::addr_mtvec:    mtvec    <= csr_w.data & ~32'h2;
                csr_pkg::addr_mscratch: mscratch <= csr_w.data;
                default: ;
            endcase
        end
    end

    // vectored mode adds four times the interrupt code.
    assign mtvec_base = {mtvec[csr_pkg::xlen-1:2], 2'b00};
    assign vec_code   = trap_pkg::irq_code(pending & enables);
    assign vec_off    = {vec_code[csr_pkg::xlen-3:0], 2'b00};
    assign trap_vec   = (trap_en || !mtvec[0]) ? mtvec_base : mtvec_base + vec_off;

    always_comb begin
        mie_word                        = '0;
        mie_word[csr_pkg::irq_meip_bit] = enables.meip;
        mie_word[csr_pkg::irq_mtip_bit] = enables.mtip;
        mie_word[csr_pkg::irq_msip_bit] = enables.msip;
        mip_word                        = '0;
        mip_word[csr_pkg::irq_meip_bit] = pending.meip;
        mip_word[csr_pkg::irq_mtip_bit] = pending.mtip;
        mip_word[csr_pkg::irq_msip_bit] = pending.msip;
    end

    // unknown addresses read as zero.
    always_comb begin
        case (csr_raddr)
            csr_pkg::addr_mstatus:  csr_rdata = mstatus_word;
            csr_pkg::addr_mie:      csr_rdata = mie_word;
            csr_pkg::addr_mtvec:    csr_rdata = mtvec;
            csr_pkg::addr_mscratch: csr_rdata = mscratch;
            csr_pkg::addr_mepc:     csr_rdata = mepc;
            csr_pkg::addr_mcause:   csr_rdata = mcause.raw;
            csr_pkg::addr_mtval:    csr_rdata = mtval;
            csr_pkg::addr_mip:      csr_rdata = mip_word;
            default:                csr_rdata = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rstn) mtvec[1] == 1'b0);

endmodule

`default_nettype wire

/* irq_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_capture (
    input  logic               clk,
    input  logic               rstn,
    input  logic               msip,
    input  logic               mtip,
    input  logic               meip,
    input  csr_pkg::csr_wr_t   csr_w,
    output trap_pkg::irq_bits_t pending
);

    trap_pkg::irq_bits_t lines;
    trap_pkg::irq_bits_t lines_d;
    trap_pkg::irq_bits_t change;
    logic                mip_wr;

    assign lines  = {meip, mtip, msip};
    assign change = lines ^ lines_d;
    assign mip_wr = csr_w.wr && (csr_w.addr == csr_pkg::addr_mip);

    // a change on a line loads its new level into the pending bit.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lines_d <= '0;
            pending <= '0;
        end else begin
            lines_d <= lines;
            if (change.meip)
                pending.meip <= meip;
            if (change.mtip)
                pending.mtip <= mtip;
            // software may set or clear msip when the line is quiet.
            if (change.msip)
                pending.msip <= msip;
            else if (mip_wr)
                pending.msip <= csr_w.data[csr_pkg::irq_msip_bit];
        end
    end

    // the timer bit follows the line with one cycle of delay.
    assert property (@(posedge clk) disable iff (!rstn)
        $past(rstn) |-> pending.mtip == $past(mtip));

endmodule

`default_nettype wire

/* machine_trap_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module machine_trap_unit (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        msip,
    input  logic                        mtip,
    input  logic                        meip,
    input  trap_pkg::trap_req_t         trap,
    input  logic                        mret,
    input  csr_pkg::csr_wr_t            csr_w,
    input  csr_pkg::csr_addr_t          csr_raddr,
    output logic                        irq_trigger,
    output logic [csr_pkg::xlen-1:0]    trap_vec,
    output logic [csr_pkg::xlen-1:0]    ret_epc,
    output logic [csr_pkg::xlen-1:0]    csr_rdata
);

    trap_pkg::irq_bits_t      pending;
    trap_pkg::irq_bits_t      enables;
    trap_pkg::cause_word_t    mcause;
    logic                     take_irq;
    logic [csr_pkg::xlen-1:0] mstatus_word;
    logic [csr_pkg::xlen-1:0] mepc;
    logic [csr_pkg::xlen-1:0] mtval;

    irq_capture u_irq_capture (
        .clk     (clk),
        .rstn    (rstn),
        .msip    (msip),
        .mtip    (mtip),
        .meip    (meip),
        .csr_w   (csr_w),
        .pending (pending)
    );

    trap_ctrl u_trap_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .trap         (trap),
        .mret         (mret),
        .csr_w        (csr_w),
        .pending      (pending),
        .enables      (enables),
        .irq_trigger  (irq_trigger),
        .take_irq     (take_irq),
        .mcause       (mcause),
        .mstatus_word (mstatus_word),
        .mepc         (mepc),
        .mtval        (mtval),
        .ret_epc      (ret_epc)
    );

    csr_regs u_csr_regs (
        .clk          (clk),
        .rstn         (rstn),
        .csr_w        (csr_w),
        .csr_raddr    (csr_raddr),
        .trap_en      (trap.en),
        .take_irq     (take_irq),
        .pending      (pending),
        .mcause       (mcause),
        .mstatus_word (mstatus_word),
        .mepc         (mepc),
        .mtval        (mtval),
        .enables      (enables),
        .trap_vec     (trap_vec),
        .csr_rdata    (csr_rdata)
    );

endmodule

`default_nettype wire

/* sim.f */
csr_pkg.sv
trap_pkg.sv
irq_capture.sv
trap_ctrl.sv
csr_regs.sv
machine_trap_unit.sv
tb_machine_trap_unit.sv

/* tb_machine_trap_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_machine_trap_unit;

    // reset, 40 random write/read pairs, directed tests, margin.
    localparam int max_cycles = 10 + 40 * 4 + 100 + 100;

    logic                  clk;
    logic                  rstn;
    logic                  msip;
    logic                  mtip;
    logic                  meip;
    logic                  mret;
    trap_pkg::trap_req_t   trap;
    csr_pkg::csr_wr_t      csr_w;
    csr_pkg::csr_addr_t    csr_raddr;
    logic                  irq_trigger;
    logic [31:0]           trap_vec;
    logic [31:0]           ret_epc;
    logic [31:0]           csr_rdata;

    // irq sets in the model are ordered {meip, mtip, msip}.
    logic                  m_mie, m_mpie;
    logic [1:0]            m_mpp, m_prv;
    logic [2:0]            m_en, m_pend, m_line, cur_line;
    logic [31:0]           m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;

    integer                seed = 32'h1b66_7e52;
    int                    errors = 0;
    int                    checks = 0;
    int                    cycles = 0;
    int                    i;
    string                 test_name;
    csr_pkg::csr_addr_t    addr_list [8];
    csr_pkg::csr_addr_t    a;

    machine_trap_unit u_dut (
        .clk (clk), .rstn (rstn), .msip (msip), .mtip (mtip), .meip (meip),
        .trap (trap), .mret (mret), .csr_w (csr_w), .csr_raddr (csr_raddr),
        .irq_trigger (irq_trigger), .trap_vec (trap_vec), .ret_epc (ret_epc),
        .csr_rdata (csr_rdata)
    );

    always #5 clk = ~clk;

    // external first, then software, then timer.
    function automatic logic [31:0] irq_code_of(input logic [2:0] act);
        if (act[2])
            return 32'd11;
        if (act[0])
            return 32'd3;
        if (act[1])
            return 32'd7;
        return 32'd0;
    endfunction

    function automatic logic [31:0] bits_word(input logic [2:0] b);
        return {20'b0, b[2], 3'b0, b[1], 3'b0, b[0], 3'b0};
    endfunction

    function automatic logic irq_expected();
        return m_mie && (|(m_pend & m_en));
    endfunction

    function automatic logic [31:0] vector_model();
        if (trap.en || !m_mtvec[0])
            return m_mtvec & ~32'h3;
        return (m_mtvec & ~32'h3) + 4 * irq_code_of(m_pend & m_en);
    endfunction

    function automatic logic [31:0] ref_read(input csr_pkg::csr_addr_t addr);
        case (addr)
            csr_pkg::addr_mstatus:  return {19'b0, m_mpp, 3'b0, m_mpie, 3'b0, m_mie, 3'b0};
            csr_pkg::addr_mie:      return bits_word(m_en);
            csr_pkg::addr_mtvec:    return m_mtvec;
            csr_pkg::addr_mscratch: return m_mscratch;
            csr_pkg::addr_mepc:     return m_mepc;
            csr_pkg::addr_mcause:   return m_mcause;
            csr_pkg::addr_mtval:    return m_mtval;
            csr_pkg::addr_mip:      return bits_word(m_pend);
            default:                return 32'h0;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: %s expected %08h, actual %08h", test_name, what, exp, act);
        end
    endtask

    task automatic csr_write(input csr_pkg::csr_addr_t addr, input logic [31:0] data);
        @(posedge clk);
        csr_w <= {1'b1, addr, data};
        @(posedge clk);
        csr_w.wr <= 1'b0;
    endtask

    task automatic read_addr(input csr_pkg::csr_addr_t addr);
        @(posedge clk);
        csr_raddr <= addr;
        @(negedge clk);
    endtask

    task automatic take_trap(input logic [31:0] cause, input logic [31:0] val,
                             input logic [31:0] epc, input logic [31:0] vec);
        @(posedge clk);
        trap <= {1'b1, cause, val, epc};
        @(negedge clk);
        check("trap_vec at entry", vec, trap_vec);
        @(posedge clk);
        trap.en <= 1'b0;
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        @(negedge clk);
        while (!irq_trigger && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!irq_trigger) begin
            errors++;
            $display("irq_trigger did not rise within 8 cycles in test %s", test_name);
        end
    endtask

    // cycle model with one event per edge in the order trap, interrupt, mret, csr write.
    always @(posedge clk) begin
        cur_line = {meip, mtip, msip};
        if (!rstn) begin
            {m_mie, m_mpie, m_mpp, m_en, m_pend, m_line} = '0;
            {m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval} = '0;
            m_prv = 2'd3;
        end else begin
            if (trap.en || irq_expected()) begin
                m_mepc   = trap.epc;
                m_mcause = trap.en ? trap.cause.raw : 32'h8000_0000 | irq_code_of(m_pend & m_en);
                m_mtval  = trap.en ? trap.val : 32'h0;
                m_mpie   = m_mie;
                m_mie    = 1'b0;
                m_mpp    = m_prv;
                m_prv    = 2'd3;
            end else if (mret) begin
                m_mie  = m_mpie;
                m_mpie = 1'b1;
                m_prv  = m_mpp;
                m_mpp  = 2'd0;
            end else if (csr_w.wr) begin
                case (csr_w.addr)
                    csr_pkg::addr_mstatus: begin
                        m_mie  = csr_w.data[3];
                        m_mpie = csr_w.data[7];
                        m_mpp  = (csr_w.data[12:11] == 2'd3) ? 2'd3 : 2'd0;
                    end
                    csr_pkg::addr_mie:      m_en = {csr_w.data[11], csr_w.data[7], csr_w.data[3]};
                    csr_pkg::addr_mtvec:    m_mtvec = csr_w.data & ~32'h2;
                    csr_pkg::addr_mscratch: m_mscratch = csr_w.data;
                    csr_pkg::addr_mepc:     m_mepc = csr_w.data & ~32'h3;
                    csr_pkg::addr_mcause:   m_mcause = csr_w.data;
                    csr_pkg::addr_mtval:    m_mtval = csr_w.data;
                    default: ;
                endcase
            end
            // an edge on the msip line wins over a software write.
            if (cur_line[0] == m_line[0] && csr_w.wr && csr_w.addr == csr_pkg::addr_mip)
                m_pend[0] = csr_w.data[3];
            for (i = 0; i < 3; i++)
                if (cur_line[i] != m_line[i])
                    m_pend[i] = cur_line[i];
            m_line = cur_line;
        end
    end

    always @(negedge clk) begin
        if (rstn) begin
            check("csr_rdata", ref_read(csr_raddr), csr_rdata);
            check("trap_vec", vector_model(), trap_vec);
            check("irq_trigger", {31'b0, irq_expected()}, {31'b0, irq_trigger});
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        {msip, mtip, meip, mret} = '0;
        trap = '0;
        csr_w = '0;
        csr_raddr = '0;
        addr_list = '{csr_pkg::addr_mstatus, csr_pkg::addr_mie, csr_pkg::addr_mtvec,
                      csr_pkg::addr_mscratch, csr_pkg::addr_mepc, csr_pkg::addr_mcause,
                      csr_pkg::addr_mtval, csr_pkg::addr_mip};
        repeat (10) @(posedge clk);
        rstn <= 1'b1;

        test_name = "reset";
        foreach (addr_list[k]) begin
            read_addr(addr_list[k]);
            check("reset value", 32'h0, csr_rdata);
        end

        test_name = "random rw";
        repeat (40) begin
            a = addr_list[$unsigned($random(seed)) % 8];
            csr_write(a, $random(seed));
            read_addr(a);
        end
        read_addr(12'h7c0);
        check("unmapped read", 32'h0, csr_rdata);

        test_name = "sync trap";
        repeat (3) @(posedge clk);
        csr_write(csr_pkg::addr_mstatus, 32'h0);
        csr_write(csr_pkg::addr_mie, 32'h0);
        csr_write(csr_pkg::addr_mip, 32'h0);
        csr_write(csr_pkg::addr_mtvec, 32'h0000_1001);
        csr_write(csr_pkg::addr_mstatus, 32'h8);
        take_trap(32'd2, 32'hdead_beef, 32'h0000_4444, 32'h0000_1000);
        read_addr(csr_pkg::addr_mcause);
        check("mcause", 32'd2, csr_rdata);
        read_addr(csr_pkg::addr_mepc);
        check("mepc", 32'h0000_4444, csr_rdata);
        read_addr(csr_pkg::addr_mtval);
        check("mtval", 32'hdead_beef, csr_rdata);
        read_addr(csr_pkg::addr_mstatus);
        check("mstatus", 32'h0000_1880, csr_rdata);

        test_name = "timer irq";
        csr_write(csr_pkg::addr_mtvec, 32'h0000_2001);
        csr_write(csr_pkg::addr_mie, 32'h80);
        csr_write(csr_pkg::addr_mstatus, 32'h8);
        @(posedge clk);
        mtip <= 1'b1;
        wait_irq();
        check("vectored trap_vec", 32'h0000_201c, trap_vec);
        @(negedge clk);
        check("irq_trigger after entry", 32'h0, {31'b0, irq_trigger});
        read_addr(csr_pkg::addr_mcause);
        check("mcause", 32'h8000_0007, csr_rdata);
        read_addr(csr_pkg::addr_mtval);
        check("mtval", 32'h0, csr_rdata);

        test_name = "irq priority";
        csr_write(csr_pkg::addr_mie, 32'h880);
        @(posedge clk);
        meip <= 1'b1;
        repeat (2) @(posedge clk);
        csr_write(csr_pkg::addr_mstatus, 32'h8);
        wait_irq();
        check("vectored trap_vec", 32'h0000_202c, trap_vec);
        read_addr(csr_pkg::addr_mcause);
        check("mcause", 32'h8000_000b, csr_rdata);
        @(posedge clk);
        mtip <= 1'b0;
        meip <= 1'b0;

        test_name = "mret";
        csr_write(csr_pkg::addr_mstatus, 32'h80);
        @(posedge clk);
        mret <= 1'b1;
        @(negedge clk);
        check("ret_epc", 32'h0000_4444, ret_epc);
        @(posedge clk);
        mret <= 1'b0;
        read_addr(csr_pkg::addr_mstatus);
        check("mstatus after mret", 32'h88, csr_rdata);
        csr_write(csr_pkg::addr_mstatus, 32'h1800);
        take_trap(32'd8, 32'h0, 32'h0000_5550, 32'h0000_2000);
        read_addr(csr_pkg::addr_mstatus);
        check("mstatus from user", 32'h0, csr_rdata);

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* trap_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl (
    input  logic                        clk,
    input  logic                        rstn,
    input  trap_pkg::trap_req_t         trap,
    input  logic                        mret,
    input  csr_pkg::csr_wr_t            csr_w,
    input  trap_pkg::irq_bits_t         pending,
    input  trap_pkg::irq_bits_t         enables,
    output logic                        irq_trigger,
    output logic                        take_irq,
    output trap_pkg::cause_word_t       mcause,
    output logic [csr_pkg::xlen-1:0]    mstatus_word,
    output logic [csr_pkg::xlen-1:0]    mepc,
    output logic [csr_pkg::xlen-1:0]    mtval,
    output logic [csr_pkg::xlen-1:0]    ret_epc
);

    trap_pkg::priv_t        prv;
    trap_pkg::priv_t        mpp;
    logic                   status_mie;
    logic                   status_mpie;
    trap_pkg::irq_bits_t    active;
    trap_pkg::cause_word_t  irq_cause;
    logic                   csr_ok;
    logic [1:0]             wr_mpp;

    assign active      = pending & enables;
    assign irq_trigger = status_mie && (|active);
    assign take_irq    = irq_trigger && !trap.en;
    assign ret_epc     = mepc;

    // a csr write only lands when no trap, interrupt or mret claims the cycle.
    assign csr_ok = csr_w.wr && !trap.en && !irq_trigger && !mret;
    assign wr_mpp = csr_w.data[csr_pkg::mstatus_mpp_lsb +: 2];

    // interrupt cause, flag set and code of the winning line.
    always_comb begin
        irq_cause             = '0;
        irq_cause.fields.intr = 1'b1;
        irq_cause.fields.code = trap_pkg::irq_code(active);
    end

    always_comb begin
        mstatus_word                                   = '0;
        mstatus_word[csr_pkg::mstatus_mie_bit]         = status_mie;
        mstatus_word[csr_pkg::mstatus_mpie_bit]        = status_mpie;
        mstatus_word[csr_pkg::mstatus_mpp_lsb +: 2]    = mpp;
    end

    // privilege and status stack.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prv         <= trap_pkg::prv_m;
            mpp         <= trap_pkg::prv_u;
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
        end else if (trap.en || irq_trigger) begin
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
            mpp         <= prv;
            prv         <= trap_pkg::prv_m;
        end else if (mret) begin
            status_mie  <= status_mpie;
            status_mpie <= 1'b1;
            prv         <= mpp;
            mpp         <= trap_pkg::prv_u;
        end else if (csr_ok && csr_w.addr == csr_pkg::addr_mstatus) begin
            status_mie  <= csr_w.data[csr_pkg::mstatus_mie_bit];
            status_mpie <= csr_w.data[csr_pkg::mstatus_mpie_bit];
            // illegal previous privilege falls back to user.
            if (wr_mpp == trap_pkg::prv_m)
                mpp <= trap_pkg::prv_m;
            else
                mpp <= trap_pkg::prv_u;
        end
    end

    // trap handling registers.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else if (trap.en) begin
            mepc   <= trap.epc;
            mcause <= trap.cause;
            mtval  <= trap.val;
        end else if (irq_trigger) begin
            mepc   <= trap.epc;
            mcause <= irq_cause;
            mtval  <= '0;
        end else if (csr_ok) begin
            if (csr_w.addr == csr_pkg::addr_mepc)
                mepc <= {csr_w.data[csr_pkg::xlen-1:2], 2'b00};
            if (csr_w.addr == csr_pkg::addr_mcause)
                mcause.raw <= csr_w.data;
            if (csr_w.addr == csr_pkg::addr_mtval)
                mtval <= csr_w.data;
        end
    end

    // the pipeline never retires a trap and an mret together.
    assert property (@(posedge clk) disable iff (!rstn) !(trap.en && mret));

    // return address stays word aligned, also for epc from the pipeline.
    assert property (@(posedge clk) disable iff (!rstn) mepc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* trap_pkg.sv */
`default_nettype none

package trap_pkg;

    // only machine and user privilege exist here.
    typedef enum logic [1:0] {
        prv_u = 2'd0,
        prv_m = 2'd3
    } priv_t;

    // interrupt cause codes, the interrupt flag is held apart.
    localparam logic [csr_pkg::xlen-2:0] cause_msi = 3;
    localparam logic [csr_pkg::xlen-2:0] cause_mti = 7;
    localparam logic [csr_pkg::xlen-2:0] cause_mei = 11;

    // used for both the pending set and the enable set.
    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } irq_bits_t;

    // mcause is written as a word and decoded as flag plus code.
    typedef union packed {
        logic [csr_pkg::xlen-1:0] raw;
        struct packed {
            logic                     intr;
            logic [csr_pkg::xlen-2:0] code;
        } fields;
    } cause_word_t;

    typedef struct packed {
        logic                     en;
        cause_word_t              cause;
        logic [csr_pkg::xlen-1:0] val;
        logic [csr_pkg::xlen-1:0] epc;
    } trap_req_t;

    // fixed priority: external, then software, then timer.
    function automatic logic [csr_pkg::xlen-2:0] irq_code(irq_bits_t act);
        if (act.meip)
            return cause_mei;
        else if (act.msip)
            return cause_msi;
        else if (act.mtip)
            return cause_mti;
        return '0;
    endfunction

endpackage

`default_nettype wire
